/* hdl/game_pkg.sv */
package game_pkg;

   typedef enum logic [1:0] {
      START,
      RUN0,
      RUN1,
      END
   } game_state_t;

   typedef logic [9:0] coord_t;   // screen coordinate wrapping mod 1024

   typedef struct packed {
      coord_t x;
      coord_t y;
   } pos_t;

   typedef logic [13:0] score_t;
   typedef logic [3:0]  advance_t;
   typedef logic [7:0]  key_code_t;

   typedef struct packed {
      game_state_t state;
      logic        won;
   } game_status_t;

   localparam score_t SCORE_MAX  = 14'd9999;
   localparam score_t SCORE_STEP = 14'd3;   // points per unit of height

   localparam key_code_t KEY_ENTER = 8'h5A;
   localparam key_code_t KEY_SPACE = 8'h29;
   localparam key_code_t KEY_ESC   = 8'h76;

   localparam coord_t FLOOR_Y    = 10'd479;   // fell off the bottom
   localparam coord_t MON_HEIGHT = 10'd67;
   localparam coord_t PLYR_WIDTH = 10'd60;
   localparam coord_t MON_WIDTH  = 10'd120;

endpackage

/* hdl/display_pkg.sv */
package display_pkg;

   typedef logic [11:0] pixel_t;   // 4:4:4 rgb

   typedef struct packed {
      logic   vld;
      pixel_t pixel;
   } layer_t;

   typedef struct packed {
      layer_t bullet;
      layer_t player;
      layer_t monster;
      layer_t background;
   } run_layers_t;

   typedef struct packed {
      pixel_t win;
      pixel_t lose;
   } end_pixels_t;

   typedef struct packed {
      logic [3:0] thou;
      logic [3:0] hund;
      logic [3:0] tens;
      logic [3:0] ones;
   } digits_t;

   typedef logic [15:0] led_t;

   localparam pixel_t PIX_WHITE = 12'hFFF;   // also transparent in sprites
   localparam pixel_t PIX_BLACK = 12'h000;

   localparam led_t LED_PHASE0_INIT = 16'h7FFF;
   localparam led_t LED_PHASE1_INIT = 16'hFFFE;
   localparam led_t LED_PHASE2_INIT = 16'h7FFE;
   localparam led_t LED_PHASE3_INIT = 16'hCC33;
   localparam led_t LED_PHASE3_ALT  = 16'h33CC;

   localparam logic [3:0] LED_PHASE_LEN = 4'd15;   // count reload for 16-cycle phases

endpackage

/* hdl/game_fsm.sv */
module game_fsm (
   input  logic                   clk23,
   input  logic                   rst,
   input  game_pkg::key_code_t    key_code,
   input  logic                   key_valid,
   input  logic                   score_full,
   input  game_pkg::pos_t         plyr_pos,
   input  game_pkg::pos_t         mon_pos,
   output game_pkg::game_status_t status
);
   import game_pkg::*;

   game_state_t state;
   game_state_t state_nxt;
   logic        won;
   coord_t      dy_mp;
   coord_t      dy_pm;
   coord_t      dx_mp;
   coord_t      dx_pm;
   logic        near_y;
   logic        near_x;
   logic        run_over;

   // all differences wrap at 10 bits
   assign dy_mp = mon_pos.y - plyr_pos.y;
   assign dy_pm = plyr_pos.y - mon_pos.y;
   assign dx_mp = mon_pos.x - plyr_pos.x;
   assign dx_pm = plyr_pos.x - mon_pos.x;

   assign near_y   = (dy_mp < MON_HEIGHT) || (dy_pm < MON_HEIGHT);
   assign near_x   = (dx_mp < PLYR_WIDTH) || (dx_pm < MON_WIDTH);
   assign run_over = score_full || (plyr_pos.y >= FLOOR_Y) || (near_y && near_x);

   always_comb begin
      state_nxt = state;
      case (state)
         START: if (key_valid && key_code == KEY_ENTER) state_nxt = RUN0;
         RUN0:  if (key_valid && key_code == KEY_SPACE) state_nxt = RUN1;
         RUN1:  if (run_over) state_nxt = END;
         END:   if (key_valid && key_code == KEY_ESC) state_nxt = START;
      endcase
   end

   always_ff @(posedge clk23) begin
      if (rst) begin
         state <= START;
         won   <= 1'b0;
      end else begin
         state <= state_nxt;
         if (state == RUN1 && state_nxt == END) begin
            won <= score_full;   // win only by full score
         end else if (state == END && state_nxt == START) begin
            won <= 1'b0;
         end
      end
   end

   assign status = '{state: state, won: won};

endmodule

/* hdl/score_counter.sv */
module score_counter (
   input  logic                   clk23,
   input  logic                   rst,
   input  game_pkg::game_status_t status,
   input  game_pkg::advance_t     advance,
   output game_pkg::score_t       score,
   output logic                   score_full
);
   import game_pkg::*;

   score_t      step;
   logic [14:0] sum;   // one spare bit for the carry

   assign step = SCORE_STEP * score_t'(advance);
   assign sum  = {1'b0, score} + {1'b0, step};

   always_ff @(posedge clk23) begin
      if (rst) begin
         score <= '0;
      end else begin
         case (status.state)
            RUN1: begin
               if (sum >= {1'b0, SCORE_MAX})
                  score <= SCORE_MAX;
               else
                  score <= sum[13:0];
            end
            END:     score <= score;   // frozen for the end screen
            default: score <= '0;
         endcase
      end
   end

   assign score_full = (score >= SCORE_MAX);

endmodule

/* hdl/bcd_digits.sv */
module bcd_digits (
   input  game_pkg::score_t     score,
   output display_pkg::digits_t digits
);
   import game_pkg::*;

   score_t q_thou;
   score_t r_thou;
   score_t q_hund;
   score_t r_hund;
   score_t q_tens;
   score_t r_tens;

   always_comb begin
      q_thou = score / 14'd1000;
      r_thou = score % 14'd1000;
      q_hund = r_thou / 14'd100;
      r_hund = r_thou % 14'd100;
      q_tens = r_hund / 14'd10;
      r_tens = r_hund % 14'd10;
   end

   // score never passes 9999, so each quotient fits in a digit
   assign digits.thou = q_thou[3:0];
   assign digits.hund = q_hund[3:0];
   assign digits.tens = q_tens[3:0];
   assign digits.ones = r_tens[3:0];

endmodule

/* hdl/win_led_show.sv */
module win_led_show (
   input  logic                   clk23,
   input  logic                   rst,
   input  game_pkg::game_status_t status,
   output display_pkg::led_t      led
);
   import display_pkg::*;

   logic [1:0] phase;
   logic [3:0] cnt;
   logic       phase_done;

   assign phase_done = (cnt == 4'd0);

   always_ff @(posedge clk23) begin
      if (rst) begin
         phase <= 2'd3;
         cnt   <= 4'd0;
         led   <= '0;
      end else if (!status.won) begin
         phase <= 2'd3;   // idle until the next win
         cnt   <= 4'd0;
         led   <= '0;
      end else if (phase_done) begin
         phase <= phase + 2'd1;
         cnt   <= LED_PHASE_LEN;
         case (phase)
            2'd0:    led <= LED_PHASE1_INIT;
            2'd1:    led <= LED_PHASE2_INIT;
            2'd2:    led <= LED_PHASE3_INIT;
            default: led <= LED_PHASE0_INIT;
         endcase
      end else begin
         cnt <= cnt - 4'd1;
         case (phase)
            2'd0: begin
               led <= {1'b1, led[15:1]};   // fill from the top
            end
            2'd1: begin
               led <= {led[14:0], 1'b1};
            end
            2'd2: begin
               if (cnt > (LED_PHASE_LEN >> 1))
                  led <= {2'b01, led[15:10], led[5:0], 2'b01};   // edges move in
               else
                  led <= {led[13:8], 4'b1111, led[7:2]};         // middle opens
            end
            default: begin
               if (led == LED_PHASE3_INIT)
                  led <= LED_PHASE3_ALT;
               else
                  led <= LED_PHASE3_INIT;
            end
         endcase
      end
   end

endmodule

/* hdl/layer_mux.sv */
module layer_mux (
   input  game_pkg::game_status_t    status,
   input  logic                      pixel_valid,
   input  display_pkg::run_layers_t  run_layers,
   input  display_pkg::end_pixels_t  end_pixels,
   output display_pkg::pixel_t       rgb
);
   import game_pkg::*;
   import display_pkg::*;

   pixel_t run_rgb;

   // white sprite pixels let the next layer through
   always_comb begin
      if (run_layers.bullet.vld) begin
         if (run_layers.bullet.pixel != PIX_WHITE)
            run_rgb = run_layers.bullet.pixel;
         else if (run_layers.player.vld)
            run_rgb = run_layers.player.pixel;
         else
            run_rgb = run_layers.background.pixel;
      end else if (run_layers.player.vld) begin
         if (run_layers.player.pixel != PIX_WHITE)
            run_rgb = run_layers.player.pixel;
         else
            run_rgb = run_layers.background.pixel;
      end else if (run_layers.monster.vld) begin
         if (run_layers.monster.pixel != PIX_WHITE)
            run_rgb = run_layers.monster.pixel;
         else
            run_rgb = run_layers.background.pixel;
      end else if (run_layers.background.vld) begin
         run_rgb = run_layers.background.pixel;
      end else begin
         run_rgb = PIX_WHITE;
      end
   end

   always_comb begin
      rgb = PIX_BLACK;   // blanking
      if (pixel_valid) begin
         case (status.state)
            START:      rgb = PIX_WHITE;
            RUN0, RUN1: rgb = run_rgb;
            END:        rgb = status.won ? end_pixels.win : end_pixels.lose;
         endcase
      end
   end

endmodule

/* hdl/game_top.sv */
module game_top (
   input  logic                     clk23,
   input  logic                     rst,
   input  game_pkg::key_code_t      key_code,
   input  logic                     key_valid,
   input  game_pkg::advance_t       advance,
   input  game_pkg::pos_t           plyr_pos,
   input  game_pkg::pos_t           mon_pos,
   input  logic                     pixel_valid,
   input  display_pkg::run_layers_t run_layers,
   input  display_pkg::end_pixels_t end_pixels,
   output game_pkg::game_status_t   status,
   output display_pkg::digits_t     digits,
   output display_pkg::led_t        led,
   output display_pkg::pixel_t      rgb
);
   import game_pkg::*;

   score_t score;
   logic   score_full;

   game_fsm i_game_fsm (
      .clk23      (clk23),
      .rst        (rst),
      .key_code   (key_code),
      .key_valid  (key_valid),
      .score_full (score_full),
      .plyr_pos   (plyr_pos),
      .mon_pos    (mon_pos),
      .status     (status)
   );

   score_counter i_score_counter (
      .clk23      (clk23),
      .rst        (rst),
      .status     (status),
      .advance    (advance),
      .score      (score),
      .score_full (score_full)
   );

   bcd_digits i_bcd_digits (
      .score  (score),
      .digits (digits)
   );

   win_led_show i_win_led_show (
      .clk23  (clk23),
      .rst    (rst),
      .status (status),
      .led    (led)
   );

   layer_mux i_layer_mux (
      .status      (status),
      .pixel_valid (pixel_valid),
      .run_layers  (run_layers),
      .end_pixels  (end_pixels),
      .rgb         (rgb)
   );

endmodule

/* bench/tb_tests.svh */
task automatic report_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
   $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
   errors++;
endtask

task automatic finish_test(input string name, input int errors_before);
   tests++;
   if (errors == errors_before)
      $display("%s: ok", name);
   else
      $display("%s: %0d errors", name, errors - errors_before);
endtask

task automatic send_key(input key_code_t code);
   @(posedge clk23);
   key_code  <= code;
   key_valid <= 1'b1;
   @(posedge clk23);
   key_valid <= 1'b0;
   @(negedge clk23);   // state already updated here
endtask

task automatic start_run();
   send_key(KEY_ENTER);
   send_key(KEY_SPACE);
endtask

task automatic park_sprites();
   plyr_pos <= '{x: 10'd100, y: 10'd100};
   mon_pos  <= '{x: 10'd500, y: 10'd400};
endtask

task automatic wait_status(input game_status_t want, input int limit);
   int n;
   n = 0;
   do begin
      @(negedge clk23);
      n++;
   end while (status !== want && n < limit);
   if (status !== want) begin
      $display("timeout: status %0h not reached within %0d cycles", want, limit);
      errors++;
   end
endtask

function automatic digits_t to_digits(input int v);
   digits_t d;
   d.thou = 4'(v / 1000);
   d.hund = 4'((v / 100) % 10);
   d.tens = 4'((v / 10) % 10);
   d.ones = 4'(v % 10);
   return d;
endfunction

function automatic logic hits_monster(input pos_t p, input pos_t m);
   coord_t up;
   coord_t down;
   coord_t right;
   coord_t left;
   up    = m.y - p.y;   // wraps at 10 bits
   down  = p.y - m.y;
   right = m.x - p.x;
   left  = p.x - m.x;
   return (up < MON_HEIGHT || down < MON_HEIGHT) && (right < PLYR_WIDTH || left < MON_WIDTH);
endfunction

function automatic layer_t random_layer();
   logic [31:0] r;
   layer_t      l;
   r       = $random(seed);
   l.vld   = r[0];
   l.pixel = (r[2:1] == 2'b00) ? PIX_WHITE : r[14:3];   // white one time in four
   return l;
endfunction

function automatic pixel_t layered_pixel(input run_layers_t l);
   if (l.bullet.vld && l.bullet.pixel != PIX_WHITE)
      return l.bullet.pixel;
   if (l.bullet.vld)
      return l.player.vld ? l.player.pixel : l.background.pixel;
   if (l.player.vld)
      return (l.player.pixel != PIX_WHITE) ? l.player.pixel : l.background.pixel;
   if (l.monster.vld)
      return (l.monster.pixel != PIX_WHITE) ? l.monster.pixel : l.background.pixel;
   return l.background.vld ? l.background.pixel : PIX_WHITE;
endfunction

task automatic test_reset_keys();
   int e0;
   e0 = errors;
   @(negedge clk23);
   if (status.state != START) report_mismatch("status.state", 32'(status.state), 32'(START));
   if (status.won !== 1'b0) report_mismatch("status.won", 32'(status.won), 32'd0);
   if (led !== 16'h0) report_mismatch("led", 32'(led), 32'h0);
   send_key(KEY_ESC);
   if (status.state != START) report_mismatch("status.state", 32'(status.state), 32'(START));
   send_key(KEY_SPACE);
   if (status.state != START) report_mismatch("status.state", 32'(status.state), 32'(START));
   send_key(KEY_ENTER);
   if (status.state != RUN0) report_mismatch("status.state", 32'(status.state), 32'(RUN0));
   @(posedge clk23);
   key_code <= KEY_SPACE;   // no strobe
   repeat (3) @(negedge clk23);
   if (status.state != RUN0) report_mismatch("status.state", 32'(status.state), 32'(RUN0));
   send_key(KEY_SPACE);
   if (status.state != RUN1) report_mismatch("status.state", 32'(status.state), 32'(RUN1));
   finish_test("reset and keys", e0);
endtask

task automatic test_score_digits();
   int      e0;
   digits_t exp;
   e0  = errors;
   exp = to_digits(3 * 7 * 20);
   @(posedge clk23);
   advance <= 4'd7;
   repeat (20) @(posedge clk23);
   advance <= 4'd0;
   @(negedge clk23);
   if (digits !== exp) report_mismatch("digits", 32'(digits), 32'(exp));
   @(posedge clk23);
   plyr_pos.y <= FLOOR_Y;
   wait_status('{END, 1'b0}, 4);
   @(posedge clk23);
   advance <= 4'd7;   // END must hold the score
   repeat (3) @(negedge clk23);
   if (digits !== exp) report_mismatch("digits", 32'(digits), 32'(exp));
   @(posedge clk23);
   park_sprites();
   send_key(KEY_ESC);
   if (status.state != START) report_mismatch("status.state", 32'(status.state), 32'(START));
   @(negedge clk23);
   if (digits !== 16'h0000) report_mismatch("digits", 32'(digits), 32'h0);
   @(posedge clk23);
   advance <= 4'd0;
   finish_test("score and digits", e0);
endtask

task automatic test_saturate_win();
   int e0;
   int k;
   e0 = errors;
   start_run();
   @(posedge clk23);
   advance <= 4'd15;
   wait_status('{END, 1'b1}, 400);
   if (digits !== 16'h9999) report_mismatch("digits", 32'(digits), 32'h9999);
   k = 0;
   while (led !== 16'h7FFF && k < 2) begin
      @(negedge clk23);
      k++;
   end
   if (led !== 16'h7FFF) report_mismatch("led", 32'(led), 32'h7FFF);
   @(negedge clk23);
   if (led !== 16'hBFFF) report_mismatch("led", 32'(led), 32'hBFFF);
   @(posedge clk23);
   advance <= 4'd0;
   send_key(KEY_ESC);
   if (status.state != START) report_mismatch("status.state", 32'(status.state), 32'(START));
   @(negedge clk23);
   if (led !== 16'h0) report_mismatch("led", 32'(led), 32'h0);
   finish_test("saturation and win", e0);
endtask

task automatic test_monster_fall();
   int          e0;
   logic [31:0] r;
   pos_t        p;
   pos_t        m;
   game_state_t exp_st;
   e0 = errors;
   for (int i = 0; i < 12; i++) begin
      start_run();
      r      = $random(seed);
      p.x    = r[9:0];
      p.y    = {1'b0, r[18:10]};
      r      = $random(seed);
      m.x    = p.x + {2'b00, r[7:0]} - 10'd128;   // monster close to the player
      m.y    = p.y + {2'b00, r[15:8]} - 10'd128;
      exp_st = (hits_monster(p, m) || p.y >= FLOOR_Y) ? END : RUN1;
      @(posedge clk23);
      plyr_pos <= p;
      mon_pos  <= m;
      repeat (2) @(negedge clk23);
      if (status.state != exp_st) report_mismatch("status.state", 32'(status.state), 32'(exp_st));
      if (status.won !== 1'b0) report_mismatch("status.won", 32'(status.won), 32'd0);
      @(posedge clk23);
      plyr_pos.y <= FLOOR_Y;   // end the run either way
      wait_status('{END, 1'b0}, 4);
      @(posedge clk23);
      park_sprites();
      send_key(KEY_ESC);
   end
   finish_test("monster and fall", e0);
endtask

task automatic test_pixels();
   int          e0;
   run_layers_t l;
   pixel_t      exp;
   e0 = errors;
   @(posedge clk23);
   run_layers  <= {4{1'b1, 12'h123}};   // opaque sprites everywhere
   end_pixels  <= '{win: 12'h0F0, lose: 12'hF00};
   @(negedge clk23);
   if (rgb !== PIX_BLACK) report_mismatch("rgb", 32'(rgb), 32'(PIX_BLACK));
   @(posedge clk23);
   pixel_valid <= 1'b1;
   @(negedge clk23);
   if (rgb !== PIX_WHITE) report_mismatch("rgb", 32'(rgb), 32'(PIX_WHITE));
   start_run();
   for (int i = 0; i <= 24; i++) begin
      l.bullet         = random_layer();
      l.player         = random_layer();
      l.monster        = random_layer();
      l.background     = random_layer();
      l.background.vld = (i != 24);   // last case has nothing valid
      if (i == 24)
         l = '0;
      exp = layered_pixel(l);
      @(posedge clk23);
      run_layers <= l;
      @(negedge clk23);
      if (rgb !== exp) report_mismatch("rgb", 32'(rgb), 32'(exp));
   end
   @(posedge clk23);
   plyr_pos.y <= FLOOR_Y;
   wait_status('{END, 1'b0}, 4);
   if (rgb !== 12'hF00) report_mismatch("rgb", 32'(rgb), 32'hF00);
   @(posedge clk23);
   park_sprites();
   send_key(KEY_ESC);
   start_run();
   @(posedge clk23);
   advance <= 4'd15;
   wait_status('{END, 1'b1}, 400);
   if (rgb !== 12'h0F0) report_mismatch("rgb", 32'(rgb), 32'h0F0);
   @(posedge clk23);
   advance <= 4'd0;
   send_key(KEY_ESC);
   finish_test("pixel choice", e0);
endtask

/* bench/tb_game_top.sv */
module tb_game_top;
   timeunit 1ns;
   timeprecision 1ps;
   import game_pkg::*;
   import display_pkg::*;

   logic         clk23;
   logic         rst;
   key_code_t    key_code;
   logic         key_valid;
   advance_t     advance;
   pos_t         plyr_pos;
   pos_t         mon_pos;
   logic         pixel_valid;
   run_layers_t  run_layers;
   end_pixels_t  end_pixels;
   game_status_t status;
   digits_t      digits;
   led_t         led;
   pixel_t       rgb;

   int seed;
   int errors;
   int tests;

   game_top i_dut (
      .clk23       (clk23),
      .rst         (rst),
      .key_code    (key_code),
      .key_valid   (key_valid),
      .advance     (advance),
      .plyr_pos    (plyr_pos),
      .mon_pos     (mon_pos),
      .pixel_valid (pixel_valid),
      .run_layers  (run_layers),
      .end_pixels  (end_pixels),
      .status      (status),
      .digits      (digits),
      .led         (led),
      .rgb         (rgb)
   );

   `include "tb_tests.svh"

   initial begin
      clk23 = 1'b0;
      forever #20 clk23 = ~clk23;
   end

   initial begin
      seed        = 90;
      errors      = 0;
      tests       = 0;
      rst         = 1'b1;
      key_code    = '0;
      key_valid   = 1'b0;
      advance     = '0;
      plyr_pos    = '{x: 10'd100, y: 10'd100};
      mon_pos     = '{x: 10'd500, y: 10'd400};   // far from the player
      pixel_valid = 1'b0;
      run_layers  = '0;
      end_pixels  = '0;
      repeat (16) @(posedge clk23);
      rst <= 1'b0;
      test_reset_keys();
      test_score_digits();
      test_saturate_win();
      test_monster_fall();
      test_pixels();
      $display("tests run %0d, errors %0d", tests, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

/* files.f */
+incdir+bench
hdl/game_pkg.sv
hdl/display_pkg.sv
hdl/game_fsm.sv
hdl/score_counter.sv
hdl/bcd_digits.sv
hdl/win_led_show.sv
hdl/layer_mux.sv
hdl/game_top.sv
bench/tb_game_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps --top-module tb_game_top -f files.f -o tb_sim &&
./obj_dir/tb_sim | grep -F -x "=== PASS ===" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
